// File: fetch_pkg.sv
package fetch_pkg;

    // basic widths
    typedef logic [31:0] word_t;
    // two instructions per fetch, first one in the low half
    typedef logic [63:0] dword_t;

    // first fetch address out of reset
    localparam word_t RESET_PC = 32'hbfc0_0000;
    // general exception vector
    localparam word_t EXC_ENTRY = 32'hbfc0_0380;

    // bytes consumed per fetch, two words wide
    localparam int unsigned FETCH_STRIDE = 8;
    // offset of the second slot
    localparam int unsigned INSTR_BYTES = 4;

    // instruction bus request, address phase
    typedef struct packed {
        logic  valid;
        word_t addr;
    } ibus_req_t;

    // instruction bus response
    // addr_ok is combinational, data follows one cycle later
    typedef struct packed {
        logic   addr_ok;
        dword_t data;
    } ibus_resp_t;

    // pc stage to fetch1
    typedef struct packed {
        logic  valid;
        // pc not word aligned
        logic  bad_addr;
        word_t pc;
    } fetch1_t;

    // one decoded slot out of a fetch
    typedef struct packed {
        logic  valid;
        logic  bad_addr;
        word_t pc;
        // zero when the slot is invalid or faulted
        word_t instr;
    } fetch_slot_t;

    // slot pair, index 0 is the slot at pc, index 1 at pc+4
    typedef fetch_slot_t [1:0] slot_pair_t;

endpackage

// File: pipe_reg.sv
`timescale 1ns/1ps

// generic stage register
// flush wins over enable, both clear to an all-zero bubble
module pipe_reg #(
    parameter type T = logic
) (
    input  logic clk,
    input  logic reset,
    // load enable, low holds the stage
    input  logic en,
    // squash the stage contents
    input  logic flush,
    input  T     d,
    output T     q
);

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            // zero valid bits make a bubble
            q <= '0;
        end else if (en) begin
            q <= d;
        end
    end

endmodule

// File: pc_select.sv
`timescale 1ns/1ps

// next pc selection and pc register
// priority: exception, eret, saved trap, branch, saved branch, sequential
module pc_select (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 exc_valid,
    input  logic                 eret_valid,
    input  fetch_pkg::word_t     epc,
    input  logic                 branch_valid,
    input  fetch_pkg::word_t     branch_target,
    input  logic                 stall_f,
    output fetch_pkg::ibus_req_t ireq,
    output fetch_pkg::fetch1_t   pc_entry
);
    import fetch_pkg::*;

    word_t pc;
    word_t pc_next;
    // redirect targets caught while the pc was stalled
    word_t trap_save;
    word_t branch_save;
    logic  trap_saved;
    logic  branch_saved;
    logic  trap_live;
    logic  misaligned;
    // bad pc already handed to fetch1 once
    logic  bad_issued;
    // sequential path chosen this cycle
    logic  seq_sel;

    assign trap_live  = exc_valid | eret_valid;
    assign misaligned = pc[1:0] != 2'b00;

    always_comb begin
        seq_sel = 1'b0;
        if (exc_valid) begin
            pc_next = EXC_ENTRY;
        end else if (eret_valid) begin
            pc_next = epc;
        end else if (trap_saved) begin
            // an older trap beats a younger branch
            pc_next = trap_save;
        end else if (branch_valid) begin
            pc_next = branch_target;
        end else if (branch_saved) begin
            pc_next = branch_save;
        end else begin
            seq_sel = 1'b1;
            // a faulting pc parks until something redirects it
            pc_next = misaligned ? pc : pc + word_t'(FETCH_STRIDE);
        end
    end

    // pending redirect flags, dropped once the pc moves
    always_ff @(posedge clk) begin
        if (reset) begin
            trap_saved   <= 1'b0;
            branch_saved <= 1'b0;
        end else if (!stall_f) begin
            trap_saved   <= 1'b0;
            branch_saved <= 1'b0;
        end else if (trap_live) begin
            trap_saved   <= 1'b1;
            // trap squashes any branch still waiting
            branch_saved <= 1'b0;
        end else if (branch_valid && !trap_saved) begin
            branch_saved <= 1'b1;
        end
    end

    // saved targets
    always_ff @(posedge clk) begin
        if (stall_f && trap_live) begin
            trap_save <= exc_valid ? EXC_ENTRY : epc;
        end
        if (stall_f && branch_valid && !trap_live && !trap_saved) begin
            branch_save <= branch_target;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc         <= RESET_PC;
            bad_issued <= 1'b0;
        end else if (!stall_f) begin
            pc         <= pc_next;
            bad_issued <= misaligned & seq_sel;
        end
    end

    // only aligned addresses go out on the bus
    assign ireq.valid = !misaligned;
    assign ireq.addr  = pc;

    // stale pc while a redirect is pending, no entry
    assign pc_entry.valid    = !(trap_saved | branch_saved | (misaligned & bad_issued));
    assign pc_entry.bad_addr = misaligned;
    assign pc_entry.pc       = pc;

endmodule

// File: fetch_hazard.sv
`timescale 1ns/1ps

// stall and flush control for pc, fetch1 and the decode register
module fetch_hazard (
    // request on the bus this cycle
    input  logic ireq_valid,
    input  logic addr_ok,
    // decode backpressure
    input  logic stall,
    // any of exception, eret, branch
    input  logic redirect,
    output logic stall_f,
    output logic flush_f1,
    output logic stall_d,
    output logic flush_d
);

    // request posted but not taken by the bus
    logic fetch_wait;

    assign fetch_wait = ireq_valid & ~addr_ok;

    // pc holds until its request is accepted or decode frees up
    assign stall_f = fetch_wait | stall;

    // bubble into fetch1 when the bus said no and nothing else holds
    // redirect drops the wrong-path fetch
    assign flush_f1 = redirect | (fetch_wait & ~stall);

    // output register follows decode
    assign stall_d = stall;
    // pair visible in the redirect cycle is consumed there
    assign flush_d = redirect;

endmodule

// File: fetch_align.sv
`timescale 1ns/1ps

// fetch2: hold buffer and split into two slots
module fetch_align (
    input  logic                  clk,
    input  logic                  reset,
    // fetch1 entry, its data is on the bus this cycle
    input  fetch_pkg::fetch1_t    entry,
    input  fetch_pkg::dword_t     resp_data,
    // output register not loading
    input  logic                  hold,
    output fetch_pkg::fetch_slot_t [1:0] slots
);
    import fetch_pkg::*;

    // response captured on the first held cycle
    dword_t buf_data;
    logic   buf_valid;
    // data actually used for this entry
    dword_t fetch_data;
    logic   entry_ok;

    // bus data is only good for one cycle
    // keep it until the stage moves on
    always_ff @(posedge clk) begin
        if (reset) begin
            buf_valid <= 1'b0;
        end else if (hold && !buf_valid) begin
            buf_valid <= 1'b1;
        end else if (!hold) begin
            buf_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (hold && !buf_valid) begin
            buf_data <= resp_data;
        end
    end

    // replay while buffered, includes the release cycle
    assign fetch_data = buf_valid ? buf_data : resp_data;

    // usable instruction data
    assign entry_ok = entry.valid & ~entry.bad_addr;

    // slot at pc, low word
    always_comb begin
        slots[0].valid    = entry.valid;
        // fault rides on the first slot only
        slots[0].bad_addr = entry.valid & entry.bad_addr;
        slots[0].pc       = entry.pc;
        slots[0].instr    = entry_ok ? fetch_data[31:0] : '0;
    end

    // slot at pc+4, high word
    always_comb begin
        // nothing behind a faulting fetch
        slots[1].valid    = entry_ok;
        slots[1].bad_addr = 1'b0;
        slots[1].pc       = entry.pc + word_t'(INSTR_BYTES);
        slots[1].instr    = entry_ok ? fetch_data[63:32] : '0;
    end

endmodule

// File: fetch_front.sv
`timescale 1ns/1ps

// instruction fetch front end
// pc -> fetch1 -> fetch2 split -> decode register
module fetch_front (
    input  logic                   clk,
    input  logic                   reset,
    output fetch_pkg::ibus_req_t   ireq,
    input  fetch_pkg::ibus_resp_t  iresp,
    input  logic                   exc_valid,
    input  logic                   eret_valid,
    input  fetch_pkg::word_t       epc,
    input  logic                   branch_valid,
    input  fetch_pkg::word_t       branch_target,
    input  logic                   stall,
    output fetch_pkg::fetch_slot_t slot_first,
    output fetch_pkg::fetch_slot_t slot_second
);
    import fetch_pkg::*;

    logic       redirect;
    logic       stall_f;
    logic       flush_f1;
    logic       stall_d;
    logic       flush_d;
    // pc stage to fetch1
    fetch1_t    pc_entry;
    fetch1_t    f1_entry;
    // fetch2 to decode register
    slot_pair_t slot_pair;
    slot_pair_t slot_pair_q;

    // any redirect, whichever source
    assign redirect = exc_valid | eret_valid | branch_valid;

    pc_select u_pc_select (
        .clk           (clk),
        .reset         (reset),
        .exc_valid     (exc_valid),
        .eret_valid    (eret_valid),
        .epc           (epc),
        .branch_valid  (branch_valid),
        .branch_target (branch_target),
        .stall_f       (stall_f),
        .ireq          (ireq),
        .pc_entry      (pc_entry)
    );

    fetch_hazard u_fetch_hazard (
        .ireq_valid (ireq.valid),
        .addr_ok    (iresp.addr_ok),
        .stall      (stall),
        .redirect   (redirect),
        .stall_f    (stall_f),
        .flush_f1   (flush_f1),
        .stall_d    (stall_d),
        .flush_d    (flush_d)
    );

    // fetch1 moves together with the pc
    pipe_reg #(.T(fetch1_t)) u_f1_reg (
        .clk   (clk),
        .reset (reset),
        .en    (~stall_f),
        .flush (flush_f1),
        .d     (pc_entry),
        .q     (f1_entry)
    );

    fetch_align u_fetch_align (
        .clk       (clk),
        .reset     (reset),
        .entry     (f1_entry),
        .resp_data (iresp.data),
        .hold      (stall_d),
        .slots     (slot_pair)
    );

    // output register feeding decode
    pipe_reg #(.T(slot_pair_t)) u_d_reg (
        .clk   (clk),
        .reset (reset),
        .en    (~stall_d),
        .flush (flush_d),
        .d     (slot_pair),
        .q     (slot_pair_q)
    );

    assign slot_first  = slot_pair_q[0];
    assign slot_second = slot_pair_q[1];

endmodule

// File: tb_fetch_front.sv
`timescale 1ns/1ps

// directed testbench for the fetch front end
module tb_fetch_front;
    import fetch_pkg::*;

    localparam int WATCHDOG_CYCLES = 3000;

    logic        clk;
    logic        reset;
    ibus_req_t   ireq;
    ibus_resp_t  iresp;
    logic        exc_valid;
    logic        eret_valid;
    word_t       epc;
    logic        branch_valid;
    word_t       branch_target;
    logic        stall;
    fetch_slot_t slot_first;
    fetch_slot_t slot_second;

    // shared random source
    logic [31:0] lfsr = 32'haf86;
    // addr_ok from lfsr when set, else always high
    logic        random_ok;
    // expected stream state
    word_t       exp_pc;
    logic        expect_none;
    int          pair_count;
    logic        mon_on;
    // output register was holding last cycle
    logic        prev_hold;
    logic [131:0] prev_pair;

    fetch_front UUT (
        .clk           (clk),
        .reset         (reset),
        .ireq          (ireq),
        .iresp         (iresp),
        .exc_valid     (exc_valid),
        .eret_valid    (eret_valid),
        .epc           (epc),
        .branch_valid  (branch_valid),
        .branch_target (branch_target),
        .stall         (stall),
        .slot_first    (slot_first),
        .slot_second   (slot_second)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bit(output logic b);
        lfsr = lfsr_step(lfsr);
        b = lfsr[0];
    endtask

    task automatic rand_bits(input int n, output int v);
        logic b;
        v = 0;
        for (int i = 0; i < n; i++) begin
            take_bit(b);
            v = (v << 1) | int'(b);
        end
    endtask

    // instruction word seen at a byte address
    function automatic word_t instr_of(input word_t a);
        return {a[23:0], a[31:24]} ^ 32'h2468_ace1;
    endfunction

    task automatic stop_fail();
        $display("** FAIL **");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        assert (got === exp) else begin
            $display("ERR %s got %h expected %h", name, got, exp);
            stop_fail();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        assert (got === exp) else begin
            $display("ERR %s got %h expected %h", name, got, exp);
            stop_fail();
        end
    endtask

    // bus model, one cycle of data latency
    initial begin
        logic  acc;
        logic  b;
        word_t acc_addr;
        iresp.addr_ok = 1'b1;
        iresp.data    = '0;
        forever begin
            @(negedge clk);
            acc      = ireq.valid & iresp.addr_ok;
            acc_addr = ireq.addr;
            @(posedge clk);
            #2;
            if (acc) begin
                iresp.data = {instr_of(acc_addr + 32'd4), instr_of(acc_addr)};
            end else begin
                iresp.data = 64'hdead_beef_dead_beef;
            end
            if (random_ok) begin
                take_bit(b);
                iresp.addr_ok = b;
            end else begin
                iresp.addr_ok = 1'b1;
            end
        end
    end

    // compare one sampled cycle with the expected stream
    task automatic check_outputs();
        logic redir;
        logic [131:0] pair;
        redir = exc_valid | eret_valid | branch_valid;
        pair  = {slot_first, slot_second};
        if (prev_hold) begin
            assert (pair === prev_pair) else begin
                $display("ERR slot_pair got %h expected %h", pair, prev_pair);
                stop_fail();
            end
        end
        if (slot_first.valid && (!stall || redir)) begin
            if (expect_none) begin
                $display("a valid pair came out after a faulting fetch");
                stop_fail();
            end else if (exp_pc[1:0] != 2'b00) begin
                // faulting fetch, single flagged slot
                check_word("slot_first.pc", slot_first.pc, exp_pc);
                check_bit("slot_first.bad_addr", slot_first.bad_addr, 1'b1);
                check_word("slot_first.instr", slot_first.instr, 32'h0);
                check_bit("slot_second.valid", slot_second.valid, 1'b0);
                expect_none = 1'b1;
            end else begin
                check_word("slot_first.pc", slot_first.pc, exp_pc);
                check_word("slot_first.instr", slot_first.instr, instr_of(exp_pc));
                check_bit("slot_first.bad_addr", slot_first.bad_addr, 1'b0);
                check_bit("slot_second.valid", slot_second.valid, 1'b1);
                check_word("slot_second.pc", slot_second.pc, exp_pc + 32'd4);
                check_word("slot_second.instr", slot_second.instr,
                           instr_of(exp_pc + 32'd4));
                check_bit("slot_second.bad_addr", slot_second.bad_addr, 1'b0);
                exp_pc = exp_pc + 32'd8;
            end
            pair_count++;
        end else if (slot_second.valid && !slot_first.valid) begin
            $display("second slot valid without a valid first slot");
            stop_fail();
        end
        // new stream start, by priority
        if (redir) begin
            expect_none = 1'b0;
            if (exc_valid) begin
                exp_pc = EXC_ENTRY;
            end else if (eret_valid) begin
                exp_pc = epc;
            end else begin
                exp_pc = branch_target;
            end
        end
        prev_hold = stall & ~redir;
        prev_pair = pair;
    endtask

    // sample mid-cycle, all inputs settled
    initial begin
        forever begin
            @(negedge clk);
            if (mon_on) begin
                check_outputs();
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * 40);
        $display("timeout, the tests did not finish in time");
        $display("** FAIL **");
        $fatal(1, "watchdog expired");
    end

    // step to the drive point of the next cycle
    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic wait_pairs(input int n);
        int target;
        target = pair_count + n;
        while (pair_count < target) begin
            next_cycle();
        end
    endtask

    task automatic pulse_branch(input word_t t);
        branch_valid  = 1'b1;
        branch_target = t;
        next_cycle();
        branch_valid  = 1'b0;
    endtask

    task automatic pulse_eret(input word_t t);
        eret_valid = 1'b1;
        epc        = t;
        next_cycle();
        eret_valid = 1'b0;
    endtask

    task automatic pulse_exc();
        exc_valid = 1'b1;
        next_cycle();
        exc_valid = 1'b0;
    endtask

    task automatic test_sequential();
        random_ok = 1'b0;
        wait_pairs(12);
    endtask

    task automatic test_random_ok();
        random_ok = 1'b1;
        wait_pairs(20);
    endtask

    // stall bursts exercise the hold buffer
    task automatic test_stall();
        int len;
        int gap;
        repeat (8) begin
            rand_bits(3, len);
            stall = 1'b1;
            repeat (len + 1) next_cycle();
            stall = 1'b0;
            rand_bits(2, gap);
            repeat (gap + 1) next_cycle();
        end
        wait_pairs(4);
    endtask

    task automatic test_redirects();
        pulse_branch(32'h0000_1000);
        wait_pairs(3);
        pulse_eret(32'h8000_2040);
        wait_pairs(3);
        // exception beats branch in the same cycle
        exc_valid     = 1'b1;
        branch_valid  = 1'b1;
        branch_target = 32'h0000_5000;
        next_cycle();
        exc_valid     = 1'b0;
        branch_valid  = 1'b0;
        wait_pairs(3);
    endtask

    task automatic test_stall_redirect();
        stall = 1'b1;
        repeat (2) next_cycle();
        pulse_branch(32'h0000_3000);
        repeat (3) next_cycle();
        stall = 1'b0;
        wait_pairs(3);
        stall = 1'b1;
        next_cycle();
        pulse_exc();
        repeat (4) next_cycle();
        stall = 1'b0;
        wait_pairs(3);
    endtask

    task automatic test_bad_addr();
        // fixed handshake so the pc moves on the pulse edge
        random_ok = 1'b0;
        repeat (2) next_cycle();
        pulse_branch(32'h0000_4002);
        repeat (10) begin
            check_bit("ireq.valid", ireq.valid, 1'b0);
            check_word("ireq.addr", ireq.addr, 32'h0000_4002);
            next_cycle();
        end
        if (!expect_none) begin
            $display("no faulting pair came out for the misaligned branch");
            stop_fail();
        end
        random_ok = 1'b1;
        pulse_exc();
        wait_pairs(3);
    endtask

    initial begin
        reset         = 1'b1;
        stall         = 1'b0;
        exc_valid     = 1'b0;
        eret_valid    = 1'b0;
        epc           = '0;
        branch_valid  = 1'b0;
        branch_target = '0;
        random_ok     = 1'b0;
        exp_pc        = RESET_PC;
        expect_none   = 1'b0;
        pair_count    = 0;
        mon_on        = 1'b0;
        prev_hold     = 1'b0;
        prev_pair     = '0;
        repeat (2) @(posedge clk);
        #2;
        reset = 1'b0;
        check_bit("ireq.valid", ireq.valid, 1'b1);
        check_word("ireq.addr", ireq.addr, RESET_PC);
        mon_on = 1'b1;
        test_sequential();
        test_random_ok();
        test_stall();
        test_redirects();
        test_stall_redirect();
        test_bad_addr();
        $display("** PASS **");
        $finish;
    end

endmodule

// File: build.f
fetch_pkg.sv
pipe_reg.sv
pc_select.sv
fetch_hazard.sv
fetch_align.sv
fetch_front.sv
tb_fetch_front.sv

// File: run.sh
#!/bin/sh
# build and run the fetch front end testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f build.f --top-module tb_fetch_front -o tb_sim

# the simulator exits nonzero on a failure, the log decides the result
./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "\*\* FAIL \*\*" sim.log; then
    echo "simulation failed"
    exit 1
fi
if ! grep -q "\*\* PASS \*\*" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"
